/* source/board_pkg.sv */
// board-side constants and vector types, referenced by scoped name from the glue RTL
`default_nettype none

package board_pkg;

  // ======================================================================
  // board widths
  // ======================================================================
  localparam int unsigned key_count     = 4;  // push buttons KEY[3:0]
  localparam int unsigned led_pio_width = 9;  // processor led pio word
  localparam int unsigned ledr_width    = 10; // red leds on the board
  localparam int unsigned stm_width     = 28; // trace hw-event word

  typedef logic [key_count-1:0]     key_vec_t;    // one bit per key or button
  typedef logic [led_pio_width-1:0] led_pio_t;
  typedef logic [ledr_width-1:0]    ledr_t;
  typedef logic [stm_width-1:0]     stm_events_t;

  // ======================================================================
  // timing defaults, all in fpga_clk_50 cycles
  // ======================================================================
  localparam int unsigned clk_hz = 50_000_000;

  // 20 us per debounce sample
  localparam int unsigned debounce_tick_cycles = clk_hz / 50_000;

  // 50 equal samples -> about 1 ms of stable key level
  localparam int unsigned debounce_stable_ticks = 50;

  // heartbeat led flips every 500 ms, so a 1 s blink period
  localparam int unsigned heartbeat_cycles = clk_hz / 2;

endpackage : board_pkg

`default_nettype wire

/* source/hps_reset_pkg.sv */
// reset-request kinds, pulse lengths and pulse FSM encoding for the hps reset handshake
`default_nettype none

package hps_reset_pkg;

  // request vector index, one bit per kind
  typedef enum logic [1:0] {
    kind_cold  = 2'd0,
    kind_warm  = 2'd1,
    kind_debug = 2'd2
  } reset_kind_e;

  localparam int unsigned reset_req_count = 3;

  // active pulse lengths seen by the hps, in clock cycles
  localparam int unsigned cold_pulse_len  = 6;
  localparam int unsigned warm_pulse_len  = 2;
  localparam int unsigned debug_pulse_len = 32;

  // pulse FSM states
  typedef enum logic [1:0] {
    st_idle  = 2'd0, // waiting for a request edge
    st_pulse = 2'd1, // pulse running
    st_hold  = 2'd2  // waiting for request to drop
  } pulse_state_e;

endpackage : hps_reset_pkg

`default_nettype wire

/* source/heartbeat_timer.sv */
// free-running timer giving the debounce sample strobe and the heartbeat led level
`timescale 1ns/1ps
`default_nettype none

module heartbeat_timer #(
  parameter int unsigned debounce_tick_cycles = board_pkg::debounce_tick_cycles,
  parameter int unsigned heartbeat_cycles     = board_pkg::heartbeat_cycles
) (
  input  wire  fpga_clk_50,
  input  wire  hps_fpga_reset_n,
  output logic tick,      // one-cycle strobe
  output logic heartbeat  // led level
);

  // +1 keeps the width at least one bit for tiny counts
  localparam int tick_w = $clog2(debounce_tick_cycles + 1);
  localparam int hb_w   = $clog2(heartbeat_cycles + 1);

  logic [tick_w-1:0] tick_cnt;
  logic [hb_w-1:0]   hb_cnt;
  logic              tick_wrap;
  logic              hb_wrap;

  assign tick_wrap = (tick_cnt == tick_w'(debounce_tick_cycles - 1));
  assign hb_wrap   = (hb_cnt == hb_w'(heartbeat_cycles - 1));

  // ======================================================================
  // debounce tick
  // ======================================================================
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      tick_cnt <= '0;
      tick     <= 1'b0;
    end
    else
    begin
      tick_cnt <= tick_wrap ? '0 : tick_cnt + 1'b1;
      tick     <= tick_wrap; // registered, so first strobe lands N cycles after release
    end
  end

  // ======================================================================
  // heartbeat
  // ======================================================================
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      hb_cnt    <= '0;
      heartbeat <= 1'b0; // led off out of reset
    end
    else if (hb_wrap)
    begin
      hb_cnt    <= '0;
      heartbeat <= ~heartbeat;
    end
    else
      hb_cnt <= hb_cnt + 1'b1;
  end

  // strobe must stay a single cycle, the debouncer counts every high cycle
  a_tick_single : assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
    tick |=> !tick);

endmodule : heartbeat_timer

`default_nettype wire

/* source/key_debounce.sv */
// key debouncer, two-flop synchronizer plus per-key stability counters stepped by the tick strobe
`timescale 1ns/1ps
`default_nettype none

module key_debounce #(
  parameter int unsigned debounce_stable_ticks = board_pkg::debounce_stable_ticks
) (
  input  wire               fpga_clk_50,
  input  wire               hps_fpga_reset_n,
  input  wire               tick,    // sample strobe from the timer
  input  board_pkg::key_vec_t key,   // raw keys, active low
  output board_pkg::key_vec_t buttons // clean, active high
);

  localparam int cnt_w = $clog2(debounce_stable_ticks + 1);

  board_pkg::key_vec_t key_meta;  // first sync stage
  board_pkg::key_vec_t key_sync;  // second sync stage
  board_pkg::key_vec_t key_prev;  // level seen at the previous tick
  logic [cnt_w-1:0]    stable_cnt [board_pkg::key_count];

  // ======================================================================
  // synchronizer
  // ======================================================================
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      key_meta <= '1; // released keys read high
      key_sync <= '1;
    end
    else
    begin
      key_meta <= key;
      key_sync <= key_meta;
    end
  end

  // ======================================================================
  // stability counters
  // ======================================================================
  // a key level is accepted once it has matched the previous sample for
  // debounce_stable_ticks ticks in a row; any mismatch restarts the count
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      key_prev <= '1;
      buttons  <= '0; // nothing pressed
      for (int i = 0; i < board_pkg::key_count; i++)
        stable_cnt[i] <= '0;
    end
    else if (tick)
    begin
      key_prev <= key_sync;
      for (int i = 0; i < board_pkg::key_count; i++)
      begin
        if (key_sync[i] != key_prev[i])
          stable_cnt[i] <= '0; // bounce, start over
        else if (stable_cnt[i] != cnt_w'(debounce_stable_ticks))
          stable_cnt[i] <= stable_cnt[i] + 1'b1; // saturates at the limit

        // this tick takes the count to the limit (or it is already there)
        if ((key_sync[i] == key_prev[i]) &&
            (stable_cnt[i] >= cnt_w'(debounce_stable_ticks - 1)))
          buttons[i] <= ~key_sync[i]; // invert to active high
      end
    end
  end

  // outputs only move on the edge that consumed a tick
  a_btn_after_tick : assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
    $changed(buttons) |-> $past(tick));

  for (genvar gi = 0; gi < board_pkg::key_count; gi++)
  begin : g_cnt_chk
    a_cnt_bound : assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
      stable_cnt[gi] <= cnt_w'(debounce_stable_ticks));
  end

endmodule : key_debounce

`default_nettype wire

/* source/reset_pulse_fsm.sv */
// edge-to-pulse FSM, one instance per hps reset request, gives a fixed-length active-high pulse
`timescale 1ns/1ps
`default_nettype none

module reset_pulse_fsm #(
  parameter int unsigned pulse_len = hps_reset_pkg::cold_pulse_len
) (
  input  wire  fpga_clk_50,
  input  wire  hps_fpga_reset_n,
  input  wire  req,   // request level, active high
  output logic pulse  // active high, inverted at the top
);

  localparam int cnt_w = $clog2(pulse_len + 1);

  hps_reset_pkg::pulse_state_e state;
  hps_reset_pkg::pulse_state_e state_nxt;
  logic                        req_q;   // previous request sample
  logic                        req_rise;
  logic [cnt_w-1:0]            len_cnt;
  logic                        len_done;

  assign req_rise = req & ~req_q;
  assign len_done = (len_cnt == cnt_w'(pulse_len - 1));

  // ======================================================================
  // next state
  // ======================================================================
  always_comb
  begin
    state_nxt = state;
    unique case (state)
      hps_reset_pkg::st_idle:
        if (req_rise)
          state_nxt = hps_reset_pkg::st_pulse;
      hps_reset_pkg::st_pulse:
        if (len_done)
          state_nxt = hps_reset_pkg::st_hold;
      hps_reset_pkg::st_hold:
        if (!req)
          state_nxt = hps_reset_pkg::st_idle; // rearm only after request drops
      default:
        state_nxt = hps_reset_pkg::st_idle;
    endcase
  end

  // ======================================================================
  // state, length counter, output stage
  // ======================================================================
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      state   <= hps_reset_pkg::st_idle;
      req_q   <= 1'b0;
      len_cnt <= '0;
      pulse   <= 1'b0;
    end
    else
    begin
      state <= state_nxt;
      req_q <= req;
      // count only while the pulse state runs
      if (state == hps_reset_pkg::st_pulse)
        len_cnt <= len_cnt + 1'b1;
      else
        len_cnt <= '0;
      // output trails the state by one edge, pulse starts 2 edges after first sample
      pulse <= (state == hps_reset_pkg::st_pulse);
    end
  end

  // pulse length is bounded, the hps never sees a stuck reset
  a_pulse_len : assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
    pulse [*pulse_len] |=> !pulse);

  // a new pulse only ever starts out of idle (edges during pulse/hold dropped)
  a_rise_from_idle : assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
    $rose(pulse) |-> $past(state == hps_reset_pkg::st_idle, 2));

endmodule : reset_pulse_fsm

`default_nettype wire

/* source/fpga_glue_top.sv */
// fpga glue top level, wires timer, debouncer and reset pulse FSMs and builds led and trace words
`timescale 1ns/1ps
`default_nettype none

module fpga_glue_top #(
  parameter int unsigned debounce_tick_cycles  = board_pkg::debounce_tick_cycles,
  parameter int unsigned debounce_stable_ticks = board_pkg::debounce_stable_ticks,
  parameter int unsigned heartbeat_cycles      = board_pkg::heartbeat_cycles
) (
  input  wire                                       fpga_clk_50,
  input  wire                                       hps_fpga_reset_n,
  input  board_pkg::key_vec_t                       key,       // active low
  input  wire [hps_reset_pkg::reset_req_count-1:0]  reset_req, // cold, warm, debug
  input  board_pkg::led_pio_t                       led_pio,   // from processor pio
  output board_pkg::ledr_t                          ledr,
  output board_pkg::key_vec_t                       buttons,   // active high
  output logic                                      cold_reset_req_n,
  output logic                                      warm_reset_req_n,
  output logic                                      debug_reset_req_n,
  output board_pkg::stm_events_t                    stm_hw_events
);

  // zero bits above led_pio in the event word
  localparam int unsigned stm_pad =
    board_pkg::stm_width - board_pkg::led_pio_width - board_pkg::key_count;

  logic                                     tick;
  logic                                     heartbeat;
  logic [hps_reset_pkg::reset_req_count-1:0] reset_pulse; // active high, per kind

  // ======================================================================
  // timer and debouncer
  // ======================================================================
  heartbeat_timer #(
    .debounce_tick_cycles (debounce_tick_cycles),
    .heartbeat_cycles     (heartbeat_cycles)
  ) i_heartbeat_timer (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .tick             (tick),
    .heartbeat        (heartbeat)
  );

  key_debounce #(
    .debounce_stable_ticks (debounce_stable_ticks)
  ) i_key_debounce (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .tick             (tick),
    .key              (key),
    .buttons          (buttons)
  );

  // ======================================================================
  // reset request pulses
  // ======================================================================
  reset_pulse_fsm #(.pulse_len(hps_reset_pkg::cold_pulse_len)) i_pulse_cold (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .req              (reset_req[hps_reset_pkg::kind_cold]),
    .pulse            (reset_pulse[hps_reset_pkg::kind_cold])
  );

  reset_pulse_fsm #(.pulse_len(hps_reset_pkg::warm_pulse_len)) i_pulse_warm (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .req              (reset_req[hps_reset_pkg::kind_warm]),
    .pulse            (reset_pulse[hps_reset_pkg::kind_warm])
  );

  reset_pulse_fsm #(.pulse_len(hps_reset_pkg::debug_pulse_len)) i_pulse_debug (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .req              (reset_req[hps_reset_pkg::kind_debug]),
    .pulse            (reset_pulse[hps_reset_pkg::kind_debug])
  );

  // hps request inputs are active low
  assign cold_reset_req_n  = ~reset_pulse[hps_reset_pkg::kind_cold];
  assign warm_reset_req_n  = ~reset_pulse[hps_reset_pkg::kind_warm];
  assign debug_reset_req_n = ~reset_pulse[hps_reset_pkg::kind_debug];

  // ======================================================================
  // status words, no registers here
  // ======================================================================
  assign ledr          = {led_pio, heartbeat}; // bit 0 blinks
  assign stm_hw_events = {{stm_pad{1'b0}}, led_pio, buttons};

endmodule : fpga_glue_top

`default_nettype wire

/* test/fpga_glue_tb.sv */
// self-checking testbench for fpga_glue_top that the Makefile builds from flist.f and runs
`timescale 1ns/1ps
`default_nettype none

module fpga_glue_tb;

  // ======================================================================
  // test timing scaled down from the board defaults
  // ======================================================================
  localparam int clk_period   = 20;
  localparam int tick_cycles  = 4;
  localparam int stable_ticks = 5;
  localparam int hb_cycles    = 100;
  localparam int cold_len     = 6;
  localparam int warm_len     = 2;
  localparam int debug_len    = 32;
  localparam int hold_cycles  = (stable_ticks + 2) * tick_cycles; // key held this long
  localparam int max_glitch   = (stable_ticks - 1) * tick_cycles - 1;
  localparam int lat_min      = stable_ticks * tick_cycles + 3;
  localparam int lat_max      = (stable_ticks + 1) * tick_cycles + 3;
  localparam int idle_age     = 1000; // model age of a request long gone
  localparam int watchdog_cycles = 10 + 3 * (hb_cycles + 4) +
    4 * (3 * hold_cycles + max_glitch + 8) + cold_len + warm_len + debug_len + 30 + 70 + 200;

  logic                   fpga_clk_50;
  logic                   hps_fpga_reset_n;
  board_pkg::key_vec_t    key;        // active low
  logic [2:0]             reset_req;  // cold, warm, debug
  board_pkg::led_pio_t    led_pio;
  board_pkg::ledr_t       ledr;
  board_pkg::key_vec_t    buttons;
  logic                   cold_reset_req_n;
  logic                   warm_reset_req_n;
  logic                   debug_reset_req_n;
  board_pkg::stm_events_t stm_hw_events;

  // reference model
  board_pkg::key_vec_t btn_exp;   // where each button must end up
  board_pkg::key_vec_t key_q;
  int                  key_lat;   // cycles since the last key change
  logic                hb_prev;
  int                  hb_gap;    // cycles since the last heartbeat toggle
  logic [2:0]          arm;       // marks the request edge that starts a pulse
  int                  age_cold;
  int                  age_warm;
  int                  age_debug;
  logic                check_idle;
  logic                settle_chk;
  int                  error_count;
  int                  errors_before;
  int                  tests_run;
  int                  tests_failed;
  integer              seed;

  fpga_glue_top #(
    .debounce_tick_cycles  (tick_cycles),
    .debounce_stable_ticks (stable_ticks),
    .heartbeat_cycles      (hb_cycles)
  ) i_fpga_glue_top (
    .fpga_clk_50       (fpga_clk_50),
    .hps_fpga_reset_n  (hps_fpga_reset_n),
    .key               (key),
    .reset_req         (reset_req),
    .led_pio           (led_pio),
    .ledr              (ledr),
    .buttons           (buttons),
    .cold_reset_req_n  (cold_reset_req_n),
    .warm_reset_req_n  (warm_reset_req_n),
    .debug_reset_req_n (debug_reset_req_n),
    .stm_hw_events     (stm_hw_events)
  );

  initial
  begin
    fpga_clk_50 = 1'b0;
    forever #(clk_period / 2) fpga_clk_50 = ~fpga_clk_50;
  end

  function automatic int next_age(input logic start, input int age);
    if (start)
      return 1;
    return (age < idle_age) ? age + 1 : age; // saturate
  endfunction

  // an _n output is low for ages 2 to len+1 after the arming edge
  function automatic logic in_pulse(input int age, input int len);
    return (age >= 2) && (age <= len + 1);
  endfunction

  always @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      key_q     <= '1;
      key_lat   <= idle_age;
      hb_prev   <= 1'b0;
      hb_gap    <= 0;
      age_cold  <= idle_age;
      age_warm  <= idle_age;
      age_debug <= idle_age;
    end
    else
    begin
      key_q     <= key;
      key_lat   <= (key != key_q) ? 1 : next_age(1'b0, key_lat);
      hb_prev   <= ledr[0];
      hb_gap    <= (ledr[0] != hb_prev) ? 1 : hb_gap + 1;
      age_cold  <= next_age(arm[hps_reset_pkg::kind_cold], age_cold);
      age_warm  <= next_age(arm[hps_reset_pkg::kind_warm], age_warm);
      age_debug <= next_age(arm[hps_reset_pkg::kind_debug], age_debug);
    end
  end

  task automatic log_failure(input string msg);
    $display("FAILED at %0t ns: %s", $time, msg);
    error_count++;
  endtask

  // ======================================================================
  // checkers
  // ======================================================================
  a_idle : assert property (@(posedge fpga_clk_50) check_idle |->
    (cold_reset_req_n && warm_reset_req_n && debug_reset_req_n && buttons == '0 && !ledr[0]))
    else log_failure("outputs not in their reset state");

  a_hb_gap : assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
    $changed(ledr[0]) |-> hb_gap == hb_cycles)
    else log_failure($sformatf("heartbeat toggled after %0d cycles", hb_gap));

  a_btn_change : assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
    $changed(buttons) |-> buttons == btn_exp && key_lat >= lat_min && key_lat <= lat_max)
    else log_failure($sformatf("buttons %b vs %b after %0d cycles", buttons, btn_exp, key_lat));

  a_btn_settled : assert property (@(posedge fpga_clk_50) settle_chk |-> buttons == btn_exp)
    else log_failure($sformatf("buttons %b, expected %b", buttons, btn_exp));

  a_cold : assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
    cold_reset_req_n == !in_pulse(age_cold, cold_len))
    else log_failure($sformatf("cold_reset_req_n wrong at age %0d", age_cold));

  a_warm : assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
    warm_reset_req_n == !in_pulse(age_warm, warm_len))
    else log_failure($sformatf("warm_reset_req_n wrong at age %0d", age_warm));

  a_debug : assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
    debug_reset_req_n == !in_pulse(age_debug, debug_len))
    else log_failure($sformatf("debug_reset_req_n wrong at age %0d", age_debug));

  a_ledr : assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
    ledr[9:1] == led_pio)
    else log_failure($sformatf("ledr %h with led_pio %h", ledr, led_pio));

  // zero padding on top, then the led word, buttons in the low nibble
  a_stm : assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
    stm_hw_events[27:13] == '0 && stm_hw_events[12:4] == led_pio &&
    stm_hw_events[3:0] == buttons)
    else log_failure($sformatf("stm_hw_events %h", stm_hw_events));

  // ======================================================================
  // stimulus
  // ======================================================================
  task automatic advance(input int n);
    repeat (n) @(posedge fpga_clk_50);
    #2; // drive point
  endtask

  task automatic check_settled;
    settle_chk = 1'b1;
    advance(1);
    settle_chk = 1'b0;
  endtask

  task automatic wait_toggle(output bit seen);
    logic start;
    int   n;
    start = ledr[0];
    seen  = 1'b0;
    for (n = 0; n < hb_cycles + 4 && !seen; n++)
    begin
      @(posedge fpga_clk_50);
      #1 seen = (ledr[0] != start);
    end
  endtask

  task automatic debounce_key(input logic [1:0] k);
    int glitch_len;
    glitch_len = 1 + int'($unsigned($random(seed)) % max_glitch);
    key[k]     = 1'b0; // press
    btn_exp[k] = 1'b1;
    advance(hold_cycles);
    check_settled();
    key[k]     = 1'b1; // release
    btn_exp[k] = 1'b0;
    advance(hold_cycles);
    check_settled();
    key[k] = 1'b0;     // glitch too short to count
    advance(glitch_len);
    key[k] = 1'b1;
    advance(hold_cycles);
    check_settled();
  endtask

  task automatic fire_reset_req(input hps_reset_pkg::reset_kind_e kind, input int len);
    reset_req[kind] = 1'b1;
    arm[kind]       = 1'b1;
    advance(1);
    arm[kind]       = 1'b0;
    reset_req[kind] = 1'b0; // drop inside the pulse
    advance(1);
    reset_req[kind] = 1'b1; // second edge is ignored
    advance(len + 4);
    reset_req[kind] = 1'b0;
    advance(6);
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (error_count != errors_before)
    begin
      tests_failed++;
      $display("test %0d %s: failed, %0d errors", tests_run, name, error_count - errors_before);
    end
    else
      $display("test %0d %s: ok", tests_run, name);
    errors_before = error_count;
  endtask

  initial
  begin
    bit seen;
    seed             = 32'ha55666f1;
    hps_fpga_reset_n = 1'b0;
    key              = '1; // all released
    reset_req        = '0;
    led_pio          = '0;
    arm              = '0;
    btn_exp          = '0;
    check_idle       = 1'b0;
    settle_chk       = 1'b0;
    error_count      = 0;
    errors_before    = 0;
    tests_run        = 0;
    tests_failed     = 0;

    advance(1);
    check_idle = 1'b1; // edges 2..6
    advance(4);
    hps_fpga_reset_n = 1'b1;
    advance(1);
    check_idle = 1'b0;
    finish_test("reset state");

    for (int t = 0; t < 3; t++)
    begin
      wait_toggle(seen);
      if (!seen)
      begin
        $display("heartbeat LED did not toggle within %0d cycles", hb_cycles + 4);
        error_count++;
      end
    end
    advance(1);
    finish_test("heartbeat");

    for (int i = 0; i < 4; i++)
      debounce_key(2'(i));
    finish_test("debounce");

    fire_reset_req(hps_reset_pkg::kind_cold, cold_len);
    fire_reset_req(hps_reset_pkg::kind_warm, warm_len);
    fire_reset_req(hps_reset_pkg::kind_debug, debug_len);
    finish_test("reset pulses");

    key     = 4'b0101; // press keys 1 and 3 so buttons show up in the event word
    btn_exp = 4'b1010;
    repeat (64)
    begin
      led_pio = board_pkg::led_pio_t'($random(seed));
      advance(1);
    end
    finish_test("status words");

    advance(4);
    $display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
             tests_run, tests_run - tests_failed, tests_failed, error_count);
    if (error_count == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

  // run length bound
  initial
  begin
    #(watchdog_cycles * clk_period);
    $display("timeout: the run was still busy after %0d cycles and was stopped", watchdog_cycles);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule : fpga_glue_tb

`default_nettype wire

/* flist.f */
source/board_pkg.sv
source/hps_reset_pkg.sv
source/heartbeat_timer.sv
source/key_debounce.sv
source/reset_pulse_fsm.sv
source/fpga_glue_top.sv
test/fpga_glue_tb.sv

/* Makefile */
TOOL  := verilator
TOP   := fpga_glue_tb
FLIST := flist.f
MDIR  := obj_dir
FLAGS := --binary --timing --assert --timescale 1ns/1ps -j 0 --Mdir $(MDIR) --top-module $(TOP)

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(MDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(TOOL) $(FLAGS) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'PASS: all tests'

clean:
	rm -rf $(MDIR)
